//--- logic/mq_pkg.sv
package mq_pkg;

   // queue geometry
   // six slots on purpose, so the pointers take the general wrap path
   localparam int MQ_SLOTS = 6;
   // most words moved per cycle on either side
   localparam int MQ_MAX_ADD = 2;
   // data word width
   localparam int MQ_WORD_W = 16;

   // derived widths
   localparam int MQ_PTR_W = $clog2(MQ_SLOTS);
   // counts 0..MQ_MAX_ADD
   localparam int MQ_STEP_W = $clog2(MQ_MAX_ADD + 1);
   // levels 0..MQ_SLOTS, both ends inclusive
   localparam int MQ_LEVEL_W = $clog2(MQ_SLOTS + 1);

   // one data word
   typedef logic [MQ_WORD_W-1:0] mq_word_t;
   // slot index
   typedef logic [MQ_PTR_W-1:0] mq_ptr_t;
   // words moved in one cycle
   typedef logic [MQ_STEP_W-1:0] mq_step_t;
   // fill level
   typedef logic [MQ_LEVEL_W-1:0] mq_level_t;

   // write request, cnt of 0 means no write
   typedef struct packed {
      mq_step_t cnt;
      // enters the queue first
      mq_word_t word0;
      // enters second, only used when cnt is 2
      mq_word_t word1;
   } mq_enq_s;

   // head view of the queue
   typedef struct packed {
      // oldest word
      mq_word_t word0;
      // next oldest word
      mq_word_t word1;
   } mq_head_s;

endpackage

//--- logic/circular_ptr.sv
`timescale 1ns/1ps

module circular_ptr
  #(parameter int slots_p = 4
   ,parameter int max_add_p = 1
   )
   (input  logic clk
   ,input  logic reset_i
   // step for this cycle, 0..max_add_p
   ,input  logic [$clog2(max_add_p + 1)-1:0] add_i
   // current pointer
   ,output logic [((slots_p > 1) ? $clog2(slots_p) : 1)-1:0] o
   // pointer after this cycle's step
   ,output logic [((slots_p > 1) ? $clog2(slots_p) : 1)-1:0] n_o
   );

   // registered pointer and its next value
   logic [$bits(o)-1:0] ptr_r;
   logic [$bits(o)-1:0] ptr_n;

   assign o = ptr_r;
   assign n_o = ptr_n;

   // pointer moves once per edge
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         ptr_r <= '0;
      end
      else
      begin
         ptr_r <= ptr_n;
      end
   end

   if (slots_p == 1)
   begin : g_single
      // only one slot, the step has nothing to select
      assign ptr_n = '0;
   end
   else if ((slots_p & (slots_p - 1)) == 0)
   begin : g_pow2
      if (max_add_p == 1)
      begin : g_add1
         // incrementer runs ahead of add_i, add_i only drives the mux
         logic [$bits(o)-1:0] ptr_p1;

         assign ptr_p1 = ptr_r + 1'b1;
         assign ptr_n = add_i[0] ? ptr_p1 : ptr_r;
      end
      else
      begin : g_addn
         // wrap falls out of the truncation
         assign ptr_n = $bits(o)'(ptr_r + add_i);
      end
   end
   else
   begin : g_general
      // one extra bit holds the sign of the wrapped sum
      logic [$bits(o):0]   ptr_wrap;
      logic [$bits(o)-1:0] ptr_nowrap;

      // both sums side by side, the sign picks one
      assign ptr_wrap = ($bits(o) + 1)'({1'b0, ptr_r} + add_i - slots_p);
      assign ptr_nowrap = $bits(o)'(ptr_r + add_i);

      // non-negative means the sum reached slots_p and wrapped
      assign ptr_n = ptr_wrap[$bits(o)] ? ptr_nowrap : ptr_wrap[$bits(o)-1:0];
   end

endmodule

//--- logic/mq_occupancy.sv
`timescale 1ns/1ps

module mq_occupancy
   (input  logic clk
   ,input  logic reset_i
   // requested counts, 0 means idle
   ,input  mq_pkg::mq_step_t enq_cnt_i
   ,input  mq_pkg::mq_step_t deq_cnt_i
   // accepted counts, zero when the side is dropped
   ,output mq_pkg::mq_step_t wr_step_o
   ,output mq_pkg::mq_step_t rd_step_o
   ,output mq_pkg::mq_level_t level_o
   ,output logic empty_o
   ,output logic full_o
   ,output logic overflow_o
   ,output logic underflow_o
   );

   import mq_pkg::*;

   // fill level and flags, all updated on the same edge
   mq_level_t level_r;
   mq_level_t level_n;
   logic empty_r;
   logic full_r;
   logic overflow_r;
   logic underflow_r;

   // free slots at the start of the cycle
   mq_level_t free_w;
   // per side acceptance
   logic wr_ok;
   logic rd_ok;

   assign free_w = mq_level_t'(MQ_SLOTS) - level_r;

   // write checked against free space before any read this cycle
   // a read never frees room for a write on the same edge
   // counts above MQ_MAX_ADD cannot be carried and are dropped too
   assign wr_ok = (enq_cnt_i <= mq_step_t'(MQ_MAX_ADD))
                  && (mq_level_t'(enq_cnt_i) <= free_w);

   // read checked against the stored words
   assign rd_ok = (deq_cnt_i <= mq_step_t'(MQ_MAX_ADD))
                  && (mq_level_t'(deq_cnt_i) <= level_r);

   // a dropped side moves nothing
   assign wr_step_o = wr_ok ? enq_cnt_i : '0;
   assign rd_step_o = rd_ok ? deq_cnt_i : '0;

   // new level from both accepted steps
   // cannot leave 0..MQ_SLOTS since both sides were checked
   assign level_n = level_r + mq_level_t'(wr_step_o) - mq_level_t'(rd_step_o);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         level_r <= '0;
         empty_r <= 1'b1;
         full_r <= 1'b0;
         overflow_r <= 1'b0;
         underflow_r <= 1'b0;
      end
      else
      begin
         level_r <= level_n;
         // flags come from level_n so they line up with level_r
         empty_r <= (level_n == '0);
         full_r <= (level_n == mq_level_t'(MQ_SLOTS));
         // error pulses last one cycle, set again only by a new drop
         overflow_r <= ~wr_ok;
         underflow_r <= ~rd_ok;
      end
   end

   assign level_o = level_r;
   assign empty_o = empty_r;
   assign full_o = full_r;
   assign overflow_o = overflow_r;
   assign underflow_o = underflow_r;

endmodule

//--- logic/mq_storage.sv
`timescale 1ns/1ps

module mq_storage
   (input  logic clk
   // accepted write count from the occupancy block
   ,input  mq_pkg::mq_step_t wr_step_i
   // first free slot
   ,input  mq_pkg::mq_ptr_t wr_ptr_i
   // write data, cnt is ignored here, wr_step_i decides
   ,input  mq_pkg::mq_enq_s words_i
   // oldest slot
   ,input  mq_pkg::mq_ptr_t rd_ptr_i
   ,output mq_pkg::mq_head_s head_o
   );

   import mq_pkg::*;

   // slot after p, wrapping past the last slot
   function automatic mq_ptr_t next_slot(input mq_ptr_t p);
      mq_ptr_t q;
      if (p == mq_ptr_t'(MQ_SLOTS - 1))
      begin
         q = '0;
      end
      else
      begin
         q = p + 1'b1;
      end
      return q;
   endfunction

   // payload only, stale slots are never read past the level
   mq_word_t mem_r [MQ_SLOTS];

   // second slot on each side
   mq_ptr_t wr_ptr_p1;
   mq_ptr_t rd_ptr_p1;

   // write side only stores what was accepted
   logic wr_one;
   logic wr_two;

   assign wr_ptr_p1 = next_slot(wr_ptr_i);
   assign rd_ptr_p1 = next_slot(rd_ptr_i);

   assign wr_one = (wr_step_i != '0);
   assign wr_two = (wr_step_i == mq_step_t'(MQ_MAX_ADD));

   always_ff @(posedge clk)
   begin
      // word0 always lands at the write pointer
      if (wr_one)
      begin
         mem_r[wr_ptr_i] <= words_i.word0;
      end
      // word1 follows it, possibly in slot 0 after a wrap
      if (wr_two)
      begin
         mem_r[wr_ptr_p1] <= words_i.word1;
      end
   end

   // head straight from the array
   // a word written this edge shows up one cycle later
   always_comb
   begin
      head_o.word0 = mem_r[rd_ptr_i];
      head_o.word1 = mem_r[rd_ptr_p1];
   end

endmodule

//--- logic/multi_word_queue.sv
`timescale 1ns/1ps

module multi_word_queue
   (input  logic clk
   ,input  logic reset_i
   // producer side, cnt of 0 is idle
   ,input  mq_pkg::mq_enq_s enq_i
   // consumer side, 0 is idle
   ,input  mq_pkg::mq_step_t deq_cnt_i
   // two oldest words, valid up to level_o
   ,output mq_pkg::mq_head_s head_o
   ,output mq_pkg::mq_level_t level_o
   ,output logic empty_o
   ,output logic full_o
   // one cycle after a dropped request
   ,output logic overflow_o
   ,output logic underflow_o
   );

   import mq_pkg::*;

   // accepted steps
   mq_step_t wr_step;
   mq_step_t rd_step;
   // current slot pointers
   mq_ptr_t wr_ptr_q;
   mq_ptr_t rd_ptr_q;

   // decides what gets through this cycle
   mq_occupancy mq_occupancy_inst
      (.clk(clk)
      ,.reset_i(reset_i)
      ,.enq_cnt_i(enq_i.cnt)
      ,.deq_cnt_i(deq_cnt_i)
      ,.wr_step_o(wr_step)
      ,.rd_step_o(rd_step)
      ,.level_o(level_o)
      ,.empty_o(empty_o)
      ,.full_o(full_o)
      ,.overflow_o(overflow_o)
      ,.underflow_o(underflow_o)
      );

   // tail, first free slot
   // next value not needed here, storage works from the current pointer
   circular_ptr #(.slots_p(MQ_SLOTS), .max_add_p(MQ_MAX_ADD)) wr_ptr
      (.clk(clk)
      ,.reset_i(reset_i)
      ,.add_i(wr_step)
      ,.o(wr_ptr_q)
      ,.n_o()
      );

   // head, oldest stored word
   circular_ptr #(.slots_p(MQ_SLOTS), .max_add_p(MQ_MAX_ADD)) rd_ptr
      (.clk(clk)
      ,.reset_i(reset_i)
      ,.add_i(rd_step)
      ,.o(rd_ptr_q)
      ,.n_o()
      );

   mq_storage mq_storage_inst
      (.clk(clk)
      ,.wr_step_i(wr_step)
      ,.wr_ptr_i(wr_ptr_q)
      ,.words_i(enq_i)
      ,.rd_ptr_i(rd_ptr_q)
      ,.head_o(head_o)
      );

endmodule

//--- verification/multi_word_queue_asserts.sv
`timescale 1ns/1ps

module multi_word_queue_asserts
  #(parameter int slots_p = 4
   ,parameter int max_add_p = 1
   )
   (input  logic clk
   ,input  logic reset_i
   // same widths as the pointer it watches
   ,input  logic [$clog2(max_add_p + 1)-1:0] add_i
   ,input  logic [((slots_p > 1) ? $clog2(slots_p) : 1)-1:0] o
   ,input  logic [((slots_p > 1) ? $clog2(slots_p) : 1)-1:0] n_o
   );

   // failed checks, read by the testbench for its closing count
   int fail_cnt = 0;

   // pointer never leaves the slot range
   a_in_range: assert property (@(posedge clk) disable iff (reset_i)
      int'(o) < slots_p)
      else
      begin
         fail_cnt++;
         $error("pointer %0d is outside %0d slots", o, slots_p);
      end

   // reset lands on slot 0
   a_reset_zero: assert property (@(posedge clk)
      reset_i |=> (o == '0))
      else
      begin
         fail_cnt++;
         $error("pointer is not 0 after reset");
      end

   // the register takes exactly the precomputed next value
   a_follows_next: assert property (@(posedge clk) disable iff (reset_i)
      !reset_i |=> (o == $past(n_o)))
      else
      begin
         fail_cnt++;
         $error("pointer did not load the previous next value");
      end

   // next value is the step added modulo the slot count
   a_next_mod: assert property (@(posedge clk) disable iff (reset_i)
      int'(n_o) == ((int'(o) + int'(add_i)) % slots_p))
      else
      begin
         fail_cnt++;
         $error("next pointer is not the wrapped sum of pointer and step");
      end

endmodule

//--- verification/multi_word_queue_tb.sv
`timescale 1ns/1ps

module multi_word_queue_tb;

   import mq_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 8;
   // must match the directed_step calls below
   localparam int DIRECTED_CYCLES = 17;
   localparam int RANDOM_CYCLES = 400;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20;

   logic clk;
   logic reset_i;
   mq_enq_s enq_i;
   mq_step_t deq_cnt_i;
   mq_head_s head_o;
   mq_level_t level_o;
   logic empty_o;
   logic full_o;
   logic overflow_o;
   logic underflow_o;

   // expected outputs, reflect the requests of the previous edge
   mq_level_t exp_level;
   mq_word_t exp_head0;
   mq_word_t exp_head1;
   logic exp_ovf;
   logic exp_unf;

   // reference queue contents, oldest first
   mq_word_t model_q[$];

   int errors = 0;
   int ovf_seen = 0;
   int unf_seen = 0;
   int ptr_fails;
   integer seed = 95;
   // directed data, each word distinct
   mq_word_t tag = 16'hA000;

   multi_word_queue multi_word_queue_inst
      (.clk(clk)
      ,.reset_i(reset_i)
      ,.enq_i(enq_i)
      ,.deq_cnt_i(deq_cnt_i)
      ,.head_o(head_o)
      ,.level_o(level_o)
      ,.empty_o(empty_o)
      ,.full_o(full_o)
      ,.overflow_o(overflow_o)
      ,.underflow_o(underflow_o)
      );

   // pointer rules on both circular_ptr instances
   bind circular_ptr multi_word_queue_asserts
      #(.slots_p(slots_p), .max_add_p(max_add_p)) ptr_asserts_inst
      (.clk(clk)
      ,.reset_i(reset_i)
      ,.add_i(add_i)
      ,.o(o)
      ,.n_o(n_o)
      );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_mismatch(input string msg);
      errors++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   // one request on the falling edge, sampled at the next rising edge
   task automatic drive_cycle(input int wr_n, input int rd_n,
                              input mq_word_t w0, input mq_word_t w1);
      @(negedge clk);
      enq_i.cnt = mq_step_t'(wr_n);
      enq_i.word0 = w0;
      enq_i.word1 = w1;
      deq_cnt_i = mq_step_t'(rd_n);
   endtask

   task automatic directed_step(input int wr_n, input int rd_n);
      drive_cycle(wr_n, rd_n, tag, tag + 16'd1);
      tag = tag + 16'd2;
   endtask

   // reference model, same acceptance rule at every rising edge
   always @(posedge clk)
   begin : ref_model
      int fill;
      int wr_n;
      int rd_n;
      bit wr_ok;
      bit rd_ok;
      if (reset_i)
      begin
         model_q.delete();
         exp_level <= '0;
         exp_ovf <= 1'b0;
         exp_unf <= 1'b0;
      end
      else
      begin
         fill = model_q.size();
         wr_n = int'(enq_i.cnt);
         rd_n = int'(deq_cnt_i);
         // both sides judged on the level before this edge
         wr_ok = (wr_n <= MQ_SLOTS - fill);
         rd_ok = (rd_n <= fill);
         if (rd_ok)
         begin
            repeat (rd_n) void'(model_q.pop_front());
         end
         if (wr_ok && wr_n >= 1)
         begin
            model_q.push_back(enq_i.word0);
         end
         if (wr_ok && wr_n == 2)
         begin
            model_q.push_back(enq_i.word1);
         end
         ovf_seen += !wr_ok;
         unf_seen += !rd_ok;
         exp_ovf <= !wr_ok;
         exp_unf <= !rd_ok;
         exp_level <= mq_level_t'(model_q.size());
         exp_head0 <= (model_q.size() >= 1) ? model_q[0] : '0;
         exp_head1 <= (model_q.size() >= 2) ? model_q[1] : '0;
      end
   end

   // state right after reset
   a_reset_state: assert property (@(posedge clk)
      $fell(reset_i) |-> (level_o == '0) && empty_o && !full_o && !overflow_o && !underflow_o)
      else report_mismatch("outputs not in reset state after reset");

   a_level: assert property (@(posedge clk) disable iff (reset_i) level_o == exp_level)
      else report_mismatch("level_o differs from reference model");

   a_empty: assert property (@(posedge clk) disable iff (reset_i)
      empty_o == (exp_level == '0))
      else report_mismatch("empty_o does not match level 0");

   a_full: assert property (@(posedge clk) disable iff (reset_i)
      full_o == (exp_level == mq_level_t'(MQ_SLOTS)))
      else report_mismatch("full_o does not match a full queue");

   // drop pulses one cycle after the request
   a_overflow: assert property (@(posedge clk) disable iff (reset_i) overflow_o == exp_ovf)
      else report_mismatch("overflow_o differs from reference model");

   a_underflow: assert property (@(posedge clk) disable iff (reset_i) underflow_o == exp_unf)
      else report_mismatch("underflow_o differs from reference model");

   // head words only matter up to the level
   a_head0: assert property (@(posedge clk) disable iff (reset_i)
      (exp_level >= 1) |-> (head_o.word0 == exp_head0))
      else report_mismatch("head_o.word0 is not the oldest word");

   a_head1: assert property (@(posedge clk) disable iff (reset_i)
      (exp_level >= 2) |-> (head_o.word1 == exp_head1))
      else report_mismatch("head_o.word1 is not the second oldest word");

   // watchdog
   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("ERROR: simulation timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      reset_i = 1'b1;
      enq_i = '0;
      deq_cnt_i = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      // fill to full, then writes that do not fit
      directed_step(2, 0);
      directed_step(2, 0);
      directed_step(2, 0);
      directed_step(1, 0);
      // read frees room but the write is still dropped
      directed_step(2, 2);
      directed_step(1, 2);
      directed_step(0, 0);
      directed_step(2, 2);
      directed_step(2, 1);
      // drain with reads past the level
      directed_step(0, 2);
      directed_step(0, 1);
      directed_step(0, 2);
      directed_step(0, 1);
      directed_step(0, 1);
      // write accepted while the read is dropped
      directed_step(2, 1);
      directed_step(0, 2);
      directed_step(0, 0);

      // random counts 0..2 on both sides
      repeat (RANDOM_CYCLES)
      begin
         drive_cycle($unsigned($random(seed)) % 3, $unsigned($random(seed)) % 3,
                     mq_word_t'($random(seed)), mq_word_t'($random(seed)));
      end

      // idle so the last request gets checked
      drive_cycle(0, 0, '0, '0);
      repeat (2) @(posedge clk);
      // checks of the last rising edge have settled by the falling edge
      @(negedge clk);

      ptr_fails = multi_word_queue_inst.wr_ptr.ptr_asserts_inst.fail_cnt
                  + multi_word_queue_inst.rd_ptr.ptr_asserts_inst.fail_cnt;
      $display("errors: %0d queue, %0d pointer; drops seen: %0d overflow, %0d underflow",
               errors, ptr_fails, ovf_seen, unf_seen);
      if (errors == 0 && ptr_fails == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- Bender.yml
# package manifest for the multi-word circular queue
package:
  name: multi_word_queue

dependencies: {}

sources:
  # shared widths, types and request structs
  - logic/mq_pkg.sv
  # pointer block, used twice by the top level
  - logic/circular_ptr.sv
  # fill level and request acceptance
  - logic/mq_occupancy.sv
  # slot array and head view
  - logic/mq_storage.sv
  # top level
  - logic/multi_word_queue.sv

  # simulation only
  - target: test
    files:
      # pointer checks, bound from the testbench
      - verification/multi_word_queue_asserts.sv
      # testbench top
      - verification/multi_word_queue_tb.sv

//--- src.f
logic/mq_pkg.sv
logic/circular_ptr.sv
logic/mq_occupancy.sv
logic/mq_storage.sv
logic/multi_word_queue.sv
verification/multi_word_queue_asserts.sv
verification/multi_word_queue_tb.sv
